// File: Makefile
TOP := tb_mips_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	@if grep -q "Done: errors found" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "Done: no errors" sim.log || (echo "FAIL: run ended early"; exit 1)
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
logic/mips_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hazard_unit.sv
logic/debug_port.sv
logic/mips_core.sv
test/mips_core_asserts.sv
test/tb_mips_core.sv

// File: logic/debug_port.sv
`timescale 1ns/1ns

module debug_port #(
    parameter int IM_ADDR_BITS = 8,
    parameter int DM_ADDR_BITS = 6
) (
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  mips_pkg::wb_req_t            i_wb,
    input  logic [mips_pkg::NB_DATA-1:0] i_dm_data,
    output logic [mips_pkg::NB_DATA-1:0] o_wb_dat,
    output logic                         o_wb_ack,
    output logic                         o_im_we,
    output logic [IM_ADDR_BITS-1:0]      o_im_addr,
    output logic [mips_pkg::NB_DATA-1:0] o_im_data,
    output logic [DM_ADDR_BITS-1:0]      o_dm_addr
);

    logic req;
    logic sel_dm;
    logic dm_read;

    assign req    = i_wb.cyc && i_wb.stb && !o_wb_ack;       // Held request is acked once
    assign sel_dm = i_wb.adr[7];

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_wb_ack <= 1'b0;
            dm_read  <= 1'b0;
        end else begin
            o_wb_ack <= req;
            dm_read  <= req && sel_dm && !i_wb.we;
        end
    end

    assign o_im_we   = req && i_wb.we && !sel_dm;
    assign o_im_addr = i_wb.adr[IM_ADDR_BITS-1:0];
    assign o_im_data = i_wb.dat;
    assign o_dm_addr = i_wb.adr[DM_ADDR_BITS-1:0];
    assign o_wb_dat  = dm_read ? i_dm_data : '0;             // IM reads return zero

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                i_clock,
    input  logic                i_rst,
    input  mips_pkg::if_id_t    i_if_id,
    input  mips_pkg::wb_write_t i_wb,
    input  logic                i_stall,
    input  logic                i_flush,
    output mips_pkg::id_ex_t    o_id_ex
);

    logic [mips_pkg::NB_DATA-1:0] regs [32];
    logic [mips_pkg::NB_DATA-1:0] instr;
    logic [mips_pkg::NB_REG-1:0]  rs;
    logic [mips_pkg::NB_REG-1:0]  rt;
    logic [mips_pkg::NB_DATA-1:0] data_a;
    logic [mips_pkg::NB_DATA-1:0] data_b;
    mips_pkg::id_ex_t             id_next;

    assign instr = i_if_id.instr;
    assign rs    = instr[25:21];
    assign rt    = instr[20:16];

    // Same-cycle writeback is bypassed to the read
    assign data_a = (rs == '0) ? '0 : (i_wb.en && i_wb.dest == rs) ? i_wb.data : regs[rs];
    assign data_b = (rt == '0) ? '0 : (i_wb.en && i_wb.dest == rt) ? i_wb.data : regs[rt];

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (i_wb.en && i_wb.dest != '0) begin
            regs[i_wb.dest] <= i_wb.data;
        end
    end

    always_comb begin
        id_next         = '0;
        id_next.alu_op  = mips_pkg::ALU_ADD;
        id_next.pc_next = i_if_id.pc_next;
        id_next.data_a  = data_a;
        id_next.data_b  = data_b;
        id_next.imm     = {{16{instr[15]}}, instr[15:0]};
        id_next.rs      = rs;
        id_next.rt      = rt;
        id_next.rd      = instr[15:11];
        case (mips_pkg::opcode_t'(instr[31:26]))
            mips_pkg::OP_RTYPE: begin
                id_next.reg_dest  = 1'b1;
                id_next.reg_write = 1'b1;
                case (mips_pkg::funct_t'(instr[5:0]))
                    mips_pkg::F_ADDU: id_next.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::F_SUBU: id_next.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::F_AND:  id_next.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::F_OR:   id_next.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::F_SLT:  id_next.alu_op = mips_pkg::ALU_SLT;
                    default:          id_next.reg_write = 1'b0;   // Unknown funct acts as NOP
                endcase
            end
            mips_pkg::OP_ADDI: begin
                id_next.reg_write = 1'b1;
                id_next.alu_src   = 1'b1;
            end
            mips_pkg::OP_LW: begin
                id_next.reg_write  = 1'b1;
                id_next.mem_to_reg = 1'b1;
                id_next.mem_read   = 1'b1;
                id_next.alu_src    = 1'b1;
            end
            mips_pkg::OP_SW: begin
                id_next.mem_write = 1'b1;
                id_next.alu_src   = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                id_next.branch = 1'b1;
                id_next.alu_op = mips_pkg::ALU_SUB;              // Zero flag gives equality
            end
            mips_pkg::OP_HALT: id_next.halt = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_rst || i_stall || i_flush)
            o_id_ex <= '0;                                   // Bubble
        else
            o_id_ex <= id_next;
    end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  logic                         i_flush,
    input  mips_pkg::id_ex_t             i_id_ex,
    input  mips_pkg::fwd_sel_t           i_fwd_a,
    input  mips_pkg::fwd_sel_t           i_fwd_b,
    input  logic [mips_pkg::NB_DATA-1:0] i_mem_fwd,
    input  mips_pkg::wb_write_t          i_wb,
    output mips_pkg::ex_mem_t            o_ex_mem
);

    logic [mips_pkg::NB_DATA-1:0] op_a;
    logic [mips_pkg::NB_DATA-1:0] reg_b;
    logic [mips_pkg::NB_DATA-1:0] op_b;
    logic [mips_pkg::NB_DATA-1:0] alu_result;

    always_comb begin
        case (i_fwd_a)
            mips_pkg::FWD_MEM: op_a = i_mem_fwd;
            mips_pkg::FWD_WB:  op_a = i_wb.data;
            default:           op_a = i_id_ex.data_a;
        endcase
        case (i_fwd_b)
            mips_pkg::FWD_MEM: reg_b = i_mem_fwd;
            mips_pkg::FWD_WB:  reg_b = i_wb.data;
            default:           reg_b = i_id_ex.data_b;
        endcase
    end

    assign op_b = i_id_ex.alu_src ? i_id_ex.imm : reg_b;

    always_comb begin
        case (i_id_ex.alu_op)
            mips_pkg::ALU_SUB: alu_result = op_a - op_b;
            mips_pkg::ALU_AND: alu_result = op_a & op_b;
            mips_pkg::ALU_OR:  alu_result = op_a | op_b;
            mips_pkg::ALU_SLT:
                alu_result = {{(mips_pkg::NB_DATA-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default:           alu_result = op_a + op_b;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_rst || i_flush) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem.reg_write   <= i_id_ex.reg_write;
            o_ex_mem.mem_to_reg  <= i_id_ex.mem_to_reg;
            o_ex_mem.mem_read    <= i_id_ex.mem_read;
            o_ex_mem.mem_write   <= i_id_ex.mem_write;
            o_ex_mem.branch      <= i_id_ex.branch;
            o_ex_mem.halt        <= i_id_ex.halt;
            o_ex_mem.branch_addr <= i_id_ex.pc_next + i_id_ex.imm;
            o_ex_mem.zero        <= (alu_result == '0);
            o_ex_mem.alu_result  <= alu_result;
            o_ex_mem.store_data  <= reg_b;                   // Forwarded rt value for SW
            o_ex_mem.dest_reg    <= i_id_ex.reg_dest ? i_id_ex.rd : i_id_ex.rt;
        end
    end

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage #(
    parameter int IM_ADDR_BITS = 8
) (
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  logic                         i_run,
    input  logic                         i_stall,
    input  logic                         i_flush,
    input  logic                         i_branch_taken,
    input  logic [mips_pkg::NB_DATA-1:0] i_branch_addr,
    input  logic                         i_halt,
    input  logic                         i_im_we,
    input  logic [IM_ADDR_BITS-1:0]      i_im_addr,
    input  logic [mips_pkg::NB_DATA-1:0] i_im_data,
    output mips_pkg::if_id_t             o_if_id
);

    logic [mips_pkg::NB_DATA-1:0] imem [2**IM_ADDR_BITS];
    logic [mips_pkg::NB_DATA-1:0] pc;
    logic [mips_pkg::NB_DATA-1:0] instr;
    logic                         at_halt;

    assign instr   = imem[pc[IM_ADDR_BITS-1:0]];
    assign at_halt = (instr[31:26] == mips_pkg::OP_HALT);   // Stop fetching past HALT

    always_ff @(posedge i_clock) begin
        if (i_im_we)
            imem[i_im_addr] <= i_im_data;
    end

    always_ff @(posedge i_clock) begin
        if (i_rst)
            pc <= '0;
        else if (i_branch_taken)
            pc <= i_branch_addr;
        else if (i_run && !i_stall && !i_halt && !at_halt)
            pc <= pc + 1'b1;
    end

    always_ff @(posedge i_clock) begin
        if (i_rst || i_flush || !i_run) begin
            o_if_id <= '0;                                   // Zero word is a NOP
        end else if (!i_stall) begin
            o_if_id.instr   <= instr;
            o_if_id.pc_next <= pc + 1'b1;
        end
    end

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit (
    input  mips_pkg::id_ex_t   i_id_ex,
    input  mips_pkg::ex_mem_t  i_ex_mem,
    input  mips_pkg::mem_wb_t  i_mem_wb,
    input  mips_pkg::if_id_t   i_if_id,
    input  logic               i_branch_taken,
    output mips_pkg::fwd_sel_t o_fwd_a,
    output mips_pkg::fwd_sel_t o_fwd_b,
    output logic               o_stall,
    output logic               o_flush
);

    logic [mips_pkg::NB_REG-1:0] id_rs;
    logic [mips_pkg::NB_REG-1:0] id_rt;
    logic                        mem_hit_a;
    logic                        mem_hit_b;
    logic                        wb_hit_a;
    logic                        wb_hit_b;

    assign mem_hit_a = i_ex_mem.reg_write && i_ex_mem.dest_reg != '0 &&
                       i_ex_mem.dest_reg == i_id_ex.rs;
    assign mem_hit_b = i_ex_mem.reg_write && i_ex_mem.dest_reg != '0 &&
                       i_ex_mem.dest_reg == i_id_ex.rt;
    assign wb_hit_a  = i_mem_wb.reg_write && i_mem_wb.dest_reg != '0 &&
                       i_mem_wb.dest_reg == i_id_ex.rs;
    assign wb_hit_b  = i_mem_wb.reg_write && i_mem_wb.dest_reg != '0 &&
                       i_mem_wb.dest_reg == i_id_ex.rt;

    // Younger result in MEM wins
    assign o_fwd_a = mem_hit_a ? mips_pkg::FWD_MEM : wb_hit_a ? mips_pkg::FWD_WB : mips_pkg::FWD_NONE;
    assign o_fwd_b = mem_hit_b ? mips_pkg::FWD_MEM : wb_hit_b ? mips_pkg::FWD_WB : mips_pkg::FWD_NONE;

    assign id_rs   = i_if_id.instr[25:21];
    assign id_rt   = i_if_id.instr[20:16];
    assign o_stall = i_id_ex.mem_read && i_id_ex.rt != '0 &&
                     (i_id_ex.rt == id_rs || i_id_ex.rt == id_rt);   // Load-use
    assign o_flush = i_branch_taken;

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/1ns

module memory_stage #(
    parameter int DM_ADDR_BITS = 6
) (
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  mips_pkg::ex_mem_t            i_ex_mem,
    input  logic [DM_ADDR_BITS-1:0]      i_dm_addr,
    output logic [mips_pkg::NB_DATA-1:0] o_dm_data,
    output logic                         o_branch_taken,
    output logic [mips_pkg::NB_DATA-1:0] o_branch_addr,
    output mips_pkg::mem_wb_t            o_mem_wb
);

    logic [mips_pkg::NB_DATA-1:0] dmem [2**DM_ADDR_BITS];
    logic [DM_ADDR_BITS-1:0]      addr;
    logic [mips_pkg::NB_DATA-1:0] load_data;

    assign addr      = i_ex_mem.alu_result[DM_ADDR_BITS-1:0];
    assign load_data = i_ex_mem.mem_read ? dmem[addr] : '0;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < 2**DM_ADDR_BITS; i++)
                dmem[i] <= '0;
        end else if (i_ex_mem.mem_write) begin
            dmem[addr] <= i_ex_mem.store_data;
        end
    end

    // Debug read port
    always_ff @(posedge i_clock) begin
        o_dm_data <= dmem[i_dm_addr];
    end

    assign o_branch_taken = i_ex_mem.branch & i_ex_mem.zero;
    assign o_branch_addr  = i_ex_mem.branch_addr;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_mem_wb <= '0;
        end else begin
            o_mem_wb.reg_write  <= i_ex_mem.reg_write;
            o_mem_wb.mem_to_reg <= i_ex_mem.mem_to_reg;
            o_mem_wb.halt       <= i_ex_mem.halt;
            o_mem_wb.mem_data   <= load_data;
            o_mem_wb.alu_result <= i_ex_mem.alu_result;
            o_mem_wb.dest_reg   <= i_ex_mem.dest_reg;
        end
    end

endmodule

// File: logic/mips_core.sv
`timescale 1ns/1ns

module mips_core #(
    parameter int IM_ADDR_BITS = 8,
    parameter int DM_ADDR_BITS = 6
) (
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  logic                         i_run,
    input  mips_pkg::wb_req_t            i_wb,
    output logic [mips_pkg::NB_DATA-1:0] o_wb_dat,
    output logic                         o_wb_ack,
    output logic                         o_hlt
);

    mips_pkg::if_id_t             if_id;
    mips_pkg::id_ex_t             id_ex;
    mips_pkg::ex_mem_t            ex_mem;
    mips_pkg::mem_wb_t            mem_wb;
    mips_pkg::wb_write_t          wb_write;
    mips_pkg::fwd_sel_t           fwd_a;
    mips_pkg::fwd_sel_t           fwd_b;
    logic                         stall;
    logic                         flush;
    logic                         branch_taken;
    logic [mips_pkg::NB_DATA-1:0] branch_addr;
    logic                         im_we;
    logic [IM_ADDR_BITS-1:0]      im_addr;
    logic [mips_pkg::NB_DATA-1:0] im_data;
    logic [DM_ADDR_BITS-1:0]      dm_addr;
    logic [mips_pkg::NB_DATA-1:0] dm_data;

    // Writeback
    assign wb_write.en   = mem_wb.reg_write;
    assign wb_write.dest = mem_wb.dest_reg;
    assign wb_write.data = mem_wb.mem_to_reg ? mem_wb.mem_data : mem_wb.alu_result;

    always_ff @(posedge i_clock) begin
        if (i_rst)
            o_hlt <= 1'b0;
        else if (mem_wb.halt)
            o_hlt <= 1'b1;                                   // Sticky until reset
    end

    fetch_stage #(.IM_ADDR_BITS(IM_ADDR_BITS)) i_fetch_stage (
        .i_clock(i_clock), .i_rst(i_rst), .i_run(i_run), .i_stall(stall), .i_flush(flush),
        .i_branch_taken(branch_taken), .i_branch_addr(branch_addr), .i_halt(o_hlt),
        .i_im_we(im_we), .i_im_addr(im_addr), .i_im_data(im_data), .o_if_id(if_id));

    decode_stage i_decode_stage (
        .i_clock(i_clock), .i_rst(i_rst), .i_if_id(if_id), .i_wb(wb_write),
        .i_stall(stall), .i_flush(flush), .o_id_ex(id_ex));

    execute_stage i_execute_stage (
        .i_clock(i_clock), .i_rst(i_rst), .i_flush(flush), .i_id_ex(id_ex),
        .i_fwd_a(fwd_a), .i_fwd_b(fwd_b), .i_mem_fwd(ex_mem.alu_result),
        .i_wb(wb_write), .o_ex_mem(ex_mem));

    memory_stage #(.DM_ADDR_BITS(DM_ADDR_BITS)) i_memory_stage (
        .i_clock(i_clock), .i_rst(i_rst), .i_ex_mem(ex_mem), .i_dm_addr(dm_addr),
        .o_dm_data(dm_data), .o_branch_taken(branch_taken), .o_branch_addr(branch_addr),
        .o_mem_wb(mem_wb));

    hazard_unit i_hazard_unit (
        .i_id_ex(id_ex), .i_ex_mem(ex_mem), .i_mem_wb(mem_wb), .i_if_id(if_id),
        .i_branch_taken(branch_taken), .o_fwd_a(fwd_a), .o_fwd_b(fwd_b),
        .o_stall(stall), .o_flush(flush));

    debug_port #(.IM_ADDR_BITS(IM_ADDR_BITS), .DM_ADDR_BITS(DM_ADDR_BITS)) i_debug_port (
        .i_clock(i_clock), .i_rst(i_rst), .i_wb(i_wb), .i_dm_data(dm_data),
        .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack), .o_im_we(im_we), .o_im_addr(im_addr),
        .o_im_data(im_data), .o_dm_addr(dm_addr));

endmodule

// File: logic/mips_pkg.sv
package mips_pkg;

    localparam int NB_DATA = 32;
    localparam int NB_REG  = 5;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        OP_HALT  = 6'h3f
    } opcode_t;

    typedef enum logic [5:0] {
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    typedef struct packed {
        logic [NB_DATA-1:0] instr;
        logic [NB_DATA-1:0] pc_next;
    } if_id_t;

    typedef struct packed {
        logic               reg_write;
        logic               mem_to_reg;
        logic               mem_read;
        logic               mem_write;
        logic               branch;
        logic               alu_src;
        logic               reg_dest;   // 1 picks rd, 0 picks rt
        logic               halt;
        alu_op_t            alu_op;
        logic [NB_DATA-1:0] pc_next;
        logic [NB_DATA-1:0] data_a;
        logic [NB_DATA-1:0] data_b;
        logic [NB_DATA-1:0] imm;
        logic [NB_REG-1:0]  rs;
        logic [NB_REG-1:0]  rt;
        logic [NB_REG-1:0]  rd;
    } id_ex_t;

    typedef struct packed {
        logic               reg_write;
        logic               mem_to_reg;
        logic               mem_read;
        logic               mem_write;
        logic               branch;
        logic               halt;
        logic [NB_DATA-1:0] branch_addr;
        logic               zero;
        logic [NB_DATA-1:0] alu_result;
        logic [NB_DATA-1:0] store_data;
        logic [NB_REG-1:0]  dest_reg;
    } ex_mem_t;

    typedef struct packed {
        logic               reg_write;
        logic               mem_to_reg;
        logic               halt;
        logic [NB_DATA-1:0] mem_data;
        logic [NB_DATA-1:0] alu_result;
        logic [NB_REG-1:0]  dest_reg;
    } mem_wb_t;

    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [7:0]         adr;        // Bit 7 selects DM
        logic [NB_DATA-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic               en;
        logic [NB_REG-1:0]  dest;
        logic [NB_DATA-1:0] data;
    } wb_write_t;

endpackage

// File: test/mips_core_asserts.sv
`timescale 1ns/1ns

module mips_core_asserts (
    input  logic              i_clock,
    input  logic              i_rst,
    input  mips_pkg::wb_req_t i_wb,
    input  logic              i_wb_ack,
    input  logic              i_hlt
);

    int unsigned fail_count = 0;    // Read by the testbench

    a_ack_follows_req: assert property (@(posedge i_clock) disable iff (i_rst)
        (i_wb.cyc && i_wb.stb && !i_wb_ack) |=> i_wb_ack)
        else begin
            $error("bus ack missing one cycle after cyc and stb");
            fail_count = fail_count + 1;
        end

    a_ack_single: assert property (@(posedge i_clock) disable iff (i_rst)
        i_wb_ack |=> !i_wb_ack)
        else begin
            $error("bus ack lasted more than one cycle");
            fail_count = fail_count + 1;
        end

    a_ack_has_req: assert property (@(posedge i_clock) disable iff (i_rst)
        i_wb_ack |-> $past(i_wb.cyc && i_wb.stb))
        else begin
            $error("bus ack without a request in the cycle before");
            fail_count = fail_count + 1;
        end

    a_hlt_reset: assert property (@(posedge i_clock) i_rst |=> !i_hlt)
        else begin
            $error("o_hlt not cleared by reset");
            fail_count = fail_count + 1;
        end

    a_hlt_sticky: assert property (@(posedge i_clock) (i_hlt && !i_rst) |=> i_hlt)
        else begin
            $error("o_hlt dropped without reset");
            fail_count = fail_count + 1;
        end

endmodule

bind mips_core mips_core_asserts i_mips_core_asserts (
    .i_clock(i_clock), .i_rst(i_rst), .i_wb(i_wb), .i_wb_ack(o_wb_ack), .i_hlt(o_hlt));

// File: test/tb_mips_core.sv
`timescale 1ns/1ns

module tb_mips_core;

    localparam int ACK_TIMEOUT  = 20;
    localparam int HALT_TIMEOUT = 2000;
    localparam int DM_WORDS     = 64;

    logic                         i_clock;
    logic                         i_rst;
    logic                         i_run;
    mips_pkg::wb_req_t            i_wb;
    logic [mips_pkg::NB_DATA-1:0] o_wb_dat;
    logic                         o_wb_ack;
    logic                         o_hlt;

    logic [31:0] prog [$];
    logic [31:0] model_reg [32];
    logic [31:0] model_mem [DM_WORDS];
    logic [31:0] rand_state;

    mips_core #(.IM_ADDR_BITS(8), .DM_ADDR_BITS(6)) i_mips_core (
        .i_clock(i_clock), .i_rst(i_rst), .i_run(i_run), .i_wb(i_wb),
        .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack), .o_hlt(o_hlt));

    always #50 i_clock = ~i_clock;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
        else report_failure($sformatf("mismatch at time %0t: %s got %h, expected %h",
                                      $time, name, got, exp));
    endtask

    always @(negedge i_clock) begin
        if (i_mips_core.i_mips_core_asserts.fail_count != 0)
            report_failure("a bound assertion on the DUT failed");
    end

    function automatic logic [15:0] lcg_imm();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state[30:15];
    endfunction

    function automatic logic [31:0] r_type(input logic [5:0] funct, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Sequential reference model stepping one instruction at a time
    task automatic interpret();
        int          pc;
        int          steps;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] ea;
        pc    = 0;
        steps = 0;
        for (int i = 0; i < 32; i++)
            model_reg[i] = '0;
        for (int i = 0; i < DM_WORDS; i++)
            model_mem[i] = '0;
        w = prog[0];
        while (w[31:26] != mips_pkg::OP_HALT) begin
            a   = model_reg[w[25:21]];
            b   = model_reg[w[20:16]];
            imm = {{16{w[15]}}, w[15:0]};
            ea  = a + imm;
            pc  = pc + 1;
            case (w[31:26])
                mips_pkg::OP_RTYPE: begin
                    case (w[5:0])
                        mips_pkg::F_ADDU: model_reg[w[15:11]] = a + b;
                        mips_pkg::F_SUBU: model_reg[w[15:11]] = a - b;
                        mips_pkg::F_AND:  model_reg[w[15:11]] = a & b;
                        mips_pkg::F_OR:   model_reg[w[15:11]] = a | b;
                        mips_pkg::F_SLT:
                            model_reg[w[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                mips_pkg::OP_ADDI: model_reg[w[20:16]] = a + imm;
                mips_pkg::OP_LW:   model_reg[w[20:16]] = model_mem[ea[5:0]];
                mips_pkg::OP_SW:   model_mem[ea[5:0]] = b;
                mips_pkg::OP_BEQ:  if (a == b) pc = pc + imm;   // Offset from PC+1
                default: ;
            endcase
            model_reg[0] = '0;
            steps++;
            if (steps > 1000 || pc < 0 || pc >= prog.size())
                report_failure("reference model ran off the end of the program");
            w = prog[pc];
        end
    endtask

    task automatic bus_access(input logic we, input logic [7:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(negedge i_clock);
        i_wb.cyc = 1'b1;
        i_wb.stb = 1'b1;
        i_wb.we  = we;
        i_wb.adr = adr;
        i_wb.dat = wdat;
        do begin
            @(negedge i_clock);
            waited++;
            if (waited > ACK_TIMEOUT)
                report_failure("timeout waiting for bus ack");
        end while (!o_wb_ack);
        rdat = o_wb_dat;
        @(negedge i_clock);                                  // Held through the ack edge
        i_wb = '0;
    endtask

    task automatic wait_for_halt();
        int waited;
        waited = 0;
        while (!o_hlt) begin
            @(negedge i_clock);
            waited++;
            if (waited > HALT_TIMEOUT)
                report_failure("timeout waiting for o_hlt");
        end
    endtask

    task automatic apply_reset();
        @(negedge i_clock);
        i_rst = 1'b1;
        i_run = 1'b0;
        i_wb  = '0;
        repeat (10) @(negedge i_clock);
        i_rst = 1'b0;
    endtask

    task automatic run_and_check(input string label);
        logic [31:0] rdat;
        apply_reset();
        for (int i = 0; i < prog.size(); i++)
            bus_access(1'b1, 8'(i), prog[i], rdat);
        interpret();
        @(negedge i_clock);
        i_run = 1'b1;
        wait_for_halt();
        i_run = 1'b0;
        bus_access(1'b1, 8'h80 | 8'd20, 32'hdead_beef, rdat);   // DM is read only
        bus_access(1'b0, 8'h03, '0, rdat);
        check_word({"o_wb_dat (", label, " IM read)"}, rdat, 32'h0);
        for (int i = 0; i < DM_WORDS; i++) begin
            bus_access(1'b0, 8'h80 | 8'(i), '0, rdat);
            check_word($sformatf("o_wb_dat (%s dmem[%0d])", label, i), rdat, model_mem[i]);
        end
    endtask

    task automatic build_arith_program();
        prog.delete();
        prog.push_back(i_type(mips_pkg::OP_ADDI, 5'd1, 5'd0, lcg_imm()));
        prog.push_back(i_type(mips_pkg::OP_ADDI, 5'd2, 5'd1, lcg_imm()));   // MEM forward
        prog.push_back(r_type(mips_pkg::F_ADDU, 5'd3, 5'd1, 5'd2));
        prog.push_back(r_type(mips_pkg::F_SUBU, 5'd4, 5'd3, 5'd1));
        prog.push_back(r_type(mips_pkg::F_AND, 5'd5, 5'd4, 5'd3));
        prog.push_back(r_type(mips_pkg::F_OR, 5'd6, 5'd5, 5'd2));
        prog.push_back(r_type(mips_pkg::F_SLT, 5'd7, 5'd4, 5'd3));
        prog.push_back(r_type(mips_pkg::F_SLT, 5'd8, 5'd3, 5'd4));
        for (int i = 0; i < 6; i++)
            prog.push_back(i_type(mips_pkg::OP_SW, 5'(i + 3), 5'd0, 16'(i)));
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd2, 5'd0, 16'd6));
        prog.push_back({mips_pkg::OP_HALT, 26'd0});
    endtask

    task automatic build_load_use_program();
        prog.delete();
        prog.push_back(i_type(mips_pkg::OP_ADDI, 5'd1, 5'd0, lcg_imm()));
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd1, 5'd0, 16'd10));
        prog.push_back(i_type(mips_pkg::OP_LW, 5'd2, 5'd0, 16'd10));
        prog.push_back(r_type(mips_pkg::F_ADDU, 5'd3, 5'd2, 5'd1));          // Uses rs
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd3, 5'd0, 16'd11));
        prog.push_back(i_type(mips_pkg::OP_LW, 5'd4, 5'd0, 16'd11));
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd4, 5'd0, 16'd12));
        prog.push_back(i_type(mips_pkg::OP_LW, 5'd5, 5'd0, 16'd10));
        prog.push_back(r_type(mips_pkg::F_SUBU, 5'd6, 5'd1, 5'd5));          // Uses rt
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd6, 5'd0, 16'd13));
        prog.push_back({mips_pkg::OP_HALT, 26'd0});
    endtask

    task automatic build_branch_program();
        prog.delete();
        prog.push_back(i_type(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'd5));
        prog.push_back(i_type(mips_pkg::OP_ADDI, 5'd2, 5'd0, 16'd5));
        prog.push_back(i_type(mips_pkg::OP_ADDI, 5'd3, 5'd0, lcg_imm()));  // Marker
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd3, 5'd0, 16'd20));
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd3, 5'd0, 16'd21));
        prog.push_back(i_type(mips_pkg::OP_BEQ, 5'd2, 5'd1, 16'd2));        // Taken
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd0, 5'd0, 16'd20));
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd0, 5'd0, 16'd21));
        prog.push_back(i_type(mips_pkg::OP_ADDI, 5'd4, 5'd0, 16'd7));
        prog.push_back(i_type(mips_pkg::OP_BEQ, 5'd4, 5'd1, 16'd1));        // Not taken
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd4, 5'd0, 16'd22));
        prog.push_back(i_type(mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'd1));
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd0, 5'd0, 16'd20));
        prog.push_back(i_type(mips_pkg::OP_SW, 5'd1, 5'd0, 16'd23));
        prog.push_back({mips_pkg::OP_HALT, 26'd0});
    endtask

    initial begin
        i_clock    = 1'b0;
        i_rst      = 1'b1;
        i_run      = 1'b0;
        i_wb       = '0;
        rand_state = 32'd59793;
        build_arith_program();
        run_and_check("arith");
        build_load_use_program();
        run_and_check("load_use");
        build_branch_program();
        run_and_check("branch");
        if (i_mips_core.i_mips_core_asserts.fail_count != 0) begin
            report_failure("a bound assertion on the DUT failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule
